//--- Makefile
TOP := exec_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

sim:
	verilator --binary --assert --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "Simulation passed" > /dev/null

clean:
	rm -rf obj_dir

//--- files.f
logic/rv32i_pkg.sv
logic/control_rom.sv
logic/instr_buffer.sv
logic/regfile.sv
logic/execute_stage.sv
logic/exec_core.sv
verification/exec_core_tb.sv

//--- logic/control_rom.sv
module control_rom (
    input  rv32i_pkg::rv32i_word         instruction,
    output rv32i_pkg::rv32i_control_word ctrl
);
    import rv32i_pkg::*;

    rv32i_instr_u  ir;
    arith_funct3_t arith_op;

    assign ir       = instruction;
    assign arith_op = arith_funct3_t'(ir.r.funct3);

    always_comb
    begin
        ctrl.opcode = rv32i_opcode'(ir.r.opcode);
        ctrl.funct3 = ir.r.funct3;
        ctrl.funct7 = ir.r.funct7;
        ctrl.rs1    = ir.r.rs1;
        ctrl.rs2    = ir.r.rs2;
        ctrl.rd     = ir.r.rd;
        ctrl.i_imm  = {{20{ir.i.imm[11]}}, ir.i.imm};
        ctrl.s_imm  = {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
        ctrl.b_imm  = {{19{ir.b.imm12}}, ir.b.imm12, ir.b.imm11, ir.b.imm10_5,
                       ir.b.imm4_1, 1'b0};
        ctrl.u_imm  = {ir.u.imm, 12'h000};
        ctrl.j_imm  = {{11{ir.j.imm20}}, ir.j.imm20, ir.j.imm19_12, ir.j.imm11,
                       ir.j.imm10_1, 1'b0};

        ctrl.alumux1_sel    = alumux_rs1_out;
        ctrl.alumux2_sel    = alumux_i_imm;
        ctrl.cmpmux_sel     = cmpmux_rs2_out;
        ctrl.pcmux_sel      = pcmux_pc_plus4;
        ctrl.regfilemux_sel = regfilemux_alu_out;
        ctrl.aluop          = alu_ops'(ir.r.funct3);
        ctrl.cmpop          = branch_funct3_t'(ir.r.funct3);
        ctrl.load_regfile   = 1'b0;
        ctrl.data_read      = 1'b0;
        ctrl.data_write     = 1'b0;
        ctrl.load_pc        = 1'b1;  // Every instruction advances the PC.

        unique case (ctrl.opcode)
            op_imm:
            begin
                ctrl.load_regfile = 1'b1;
                unique case (arith_op)
                    slt:
                    begin
                        ctrl.cmpop          = blt;
                        ctrl.cmpmux_sel     = cmpmux_i_imm;
                        ctrl.regfilemux_sel = regfilemux_br_en;
                    end
                    sltu:
                    begin
                        ctrl.cmpop          = bltu;
                        ctrl.cmpmux_sel     = cmpmux_i_imm;
                        ctrl.regfilemux_sel = regfilemux_br_en;
                    end
                    sr:
                    begin
                        if (ctrl.funct7[5])
                            ctrl.aluop = alu_sra;  // SRAI.
                        else
                            ctrl.aluop = alu_srl;
                    end
                    default: ;
                endcase
            end
            op_reg:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.alumux2_sel  = alumux_rs2_out;
                unique case (arith_op)
                    add:
                    begin
                        if (ctrl.funct7[5])
                            ctrl.aluop = alu_sub;
                        else
                            ctrl.aluop = alu_add;
                    end
                    slt:
                    begin
                        ctrl.cmpop          = blt;
                        ctrl.regfilemux_sel = regfilemux_br_en;
                    end
                    sltu:
                    begin
                        ctrl.cmpop          = bltu;
                        ctrl.regfilemux_sel = regfilemux_br_en;
                    end
                    sr:
                    begin
                        if (ctrl.funct7[5])
                            ctrl.aluop = alu_sra;
                        else
                            ctrl.aluop = alu_srl;
                    end
                    default: ;
                endcase
            end
            op_lui:
            begin
                ctrl.load_regfile   = 1'b1;
                ctrl.regfilemux_sel = regfilemux_u_imm;
            end
            op_auipc:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.alumux1_sel  = alumux_pc_out;
                ctrl.alumux2_sel  = alumux_u_imm;
                ctrl.aluop        = alu_add;
            end
            op_load:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.data_read    = 1'b1;
                ctrl.aluop        = alu_add;
            end
            op_store:
            begin
                ctrl.data_write  = 1'b1;
                ctrl.alumux2_sel = alumux_s_imm;
                ctrl.aluop       = alu_add;
            end
            op_br:
            begin
                ctrl.cmpmux_sel  = cmpmux_rs2_out;
                ctrl.pcmux_sel   = pcmux_br_target;
                ctrl.alumux1_sel = alumux_pc_out;  // ALU forms the target.
                ctrl.alumux2_sel = alumux_b_imm;
                ctrl.aluop       = alu_add;
            end
            op_jal:
            begin
                ctrl.load_regfile   = 1'b1;
                ctrl.alumux1_sel    = alumux_pc_out;
                ctrl.alumux2_sel    = alumux_j_imm;
                ctrl.aluop          = alu_add;
                ctrl.pcmux_sel      = pcmux_alu_out;
                ctrl.regfilemux_sel = regfilemux_pc_plus4;
            end
            op_jalr:
            begin
                ctrl.load_regfile   = 1'b1;
                ctrl.aluop          = alu_add;
                ctrl.pcmux_sel      = pcmux_alu_mod2;
                ctrl.regfilemux_sel = regfilemux_pc_plus4;
            end
            default: ;
        endcase
    end

endmodule

//--- logic/exec_core.sv
module exec_core (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  rv32i_pkg::instr_pkt_t in_pkt,
    output logic                  in_credit,
    output logic                  commit_valid,
    output rv32i_pkg::commit_t    commit,
    input  logic                  commit_credit
);
    import rv32i_pkg::*;

    logic              head_valid;
    instr_pkt_t        head_pkt;
    logic              issue;
    rv32i_control_word ctrl;
    rv32i_word         rs1_data;
    rv32i_word         rs2_data;
    logic              rf_we;
    rv32i_reg          rf_rd;
    rv32i_word         rf_wdata;

    instr_buffer u_instr_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_pkt     (in_pkt),
        .in_credit  (in_credit),
        .issue      (issue),
        .head_valid (head_valid),
        .head_pkt   (head_pkt)
    );

    control_rom u_control_rom (
        .instruction (head_pkt.instr),
        .ctrl        (ctrl)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .we       (rf_we),
        .rd       (rf_rd),
        .wdata    (rf_wdata),
        .rs1      (ctrl.rs1),
        .rs2      (ctrl.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    execute_stage u_execute_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .head_valid    (head_valid),
        .pc            (head_pkt.pc),
        .ctrl          (ctrl),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .commit_credit (commit_credit),
        .issue         (issue),
        .rf_we         (rf_we),
        .rf_rd         (rf_rd),
        .rf_wdata      (rf_wdata),
        .commit_valid  (commit_valid),
        .commit        (commit)
    );

endmodule

//--- logic/execute_stage.sv
module execute_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         head_valid,
    input  rv32i_pkg::rv32i_word         pc,
    input  rv32i_pkg::rv32i_control_word ctrl,
    input  rv32i_pkg::rv32i_word         rs1_data,
    input  rv32i_pkg::rv32i_word         rs2_data,
    input  logic                         commit_credit,
    output logic                         issue,
    output logic                         rf_we,
    output rv32i_pkg::rv32i_reg          rf_rd,
    output rv32i_pkg::rv32i_word         rf_wdata,
    output logic                         commit_valid,
    output rv32i_pkg::commit_t           commit
);
    import rv32i_pkg::*;

    logic [OUT_CNT_W-1:0] credits;
    rv32i_word            alu_a;
    rv32i_word            alu_b;
    rv32i_word            cmp_b;
    rv32i_word            alu_out;
    rv32i_word            pc_plus4;
    rv32i_word            next_pc;
    rv32i_word            rd_data;
    logic                 br_en;
    logic                 br_taken;
    logic                 rd_we;

    function automatic rv32i_word alumux_out(input alumux_sel_t sel,
                                             input rv32i_word pc_v,
                                             input rv32i_word rs1_v,
                                             input rv32i_word rs2_v,
                                             input rv32i_control_word c);
        unique case (sel)
            alumux_rs1_out: alumux_out = rs1_v;
            alumux_pc_out:  alumux_out = pc_v;
            alumux_i_imm:   alumux_out = c.i_imm;
            alumux_u_imm:   alumux_out = c.u_imm;
            alumux_b_imm:   alumux_out = c.b_imm;
            alumux_s_imm:   alumux_out = c.s_imm;
            alumux_j_imm:   alumux_out = c.j_imm;
            alumux_rs2_out: alumux_out = rs2_v;
        endcase
    endfunction

    assign alu_a    = alumux_out(ctrl.alumux1_sel, pc, rs1_data, rs2_data, ctrl);
    assign alu_b    = alumux_out(ctrl.alumux2_sel, pc, rs1_data, rs2_data, ctrl);
    assign cmp_b    = (ctrl.cmpmux_sel == cmpmux_i_imm) ? ctrl.i_imm : rs2_data;
    assign pc_plus4 = pc + 32'd4;

    always_comb
    begin
        unique case (ctrl.aluop)
            alu_add: alu_out = alu_a + alu_b;
            alu_sll: alu_out = alu_a << alu_b[4:0];
            alu_sra: alu_out = rv32i_word'($signed(alu_a) >>> alu_b[4:0]);
            alu_sub: alu_out = alu_a - alu_b;
            alu_xor: alu_out = alu_a ^ alu_b;
            alu_srl: alu_out = alu_a >> alu_b[4:0];
            alu_or:  alu_out = alu_a | alu_b;
            alu_and: alu_out = alu_a & alu_b;
        endcase
    end

    always_comb
    begin
        case (ctrl.cmpop)
            beq:     br_en = (rs1_data == cmp_b);
            bne:     br_en = (rs1_data != cmp_b);
            blt:     br_en = ($signed(rs1_data) < $signed(cmp_b));
            bge:     br_en = ($signed(rs1_data) >= $signed(cmp_b));
            bltu:    br_en = (rs1_data < cmp_b);
            bgeu:    br_en = (rs1_data >= cmp_b);
            default: br_en = 1'b0;
        endcase
    end

    always_comb
    begin
        unique case (ctrl.pcmux_sel)
            pcmux_pc_plus4:  next_pc = pc_plus4;
            pcmux_alu_out:   next_pc = alu_out;
            pcmux_alu_mod2:  next_pc = {alu_out[31:1], 1'b0};  // JALR target.
            pcmux_br_target: next_pc = br_en ? alu_out : pc_plus4;
        endcase
    end

    always_comb
    begin
        unique case (ctrl.regfilemux_sel)
            regfilemux_alu_out:  rd_data = alu_out;
            regfilemux_br_en:    rd_data = {31'b0, br_en};  // SLT family.
            regfilemux_u_imm:    rd_data = ctrl.u_imm;
            regfilemux_pc_plus4: rd_data = pc_plus4;
        endcase
    end

    assign br_taken = br_en && (ctrl.pcmux_sel == pcmux_br_target);
    assign rd_we    = ctrl.load_regfile && !ctrl.data_read && (ctrl.rd != '0);
    assign issue    = head_valid && (credits != '0);
    assign rf_we    = issue && rd_we;
    assign rf_rd    = ctrl.rd;
    assign rf_wdata = rd_data;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            credits      <= OUT_CNT_W'(OUT_CREDITS);
            commit_valid <= 1'b0;
        end
        else
        begin
            credits      <= credits - OUT_CNT_W'(issue) + OUT_CNT_W'(commit_credit);
            commit_valid <= issue;
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            commit.pc        <= pc;
            commit.next_pc   <= next_pc;
            commit.rd        <= ctrl.rd;
            commit.rd_data   <= rd_data;
            commit.rd_we     <= rd_we;
            commit.mem_addr  <= alu_out;  // Load and store address.
            commit.mem_wdata <= rs2_data;
            commit.mem_read  <= ctrl.data_read;
            commit.mem_write <= ctrl.data_write;
            commit.br_taken  <= br_taken;
        end
    end

    // Downstream returns no more credits than it was granted.
    assert property (@(posedge clk) disable iff (!rst_n)
        credits <= OUT_CNT_W'(OUT_CREDITS));

endmodule

//--- logic/instr_buffer.sv
module instr_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  rv32i_pkg::instr_pkt_t in_pkt,
    output logic                  in_credit,
    input  logic                  issue,
    output logic                  head_valid,
    output rv32i_pkg::instr_pkt_t head_pkt
);
    import rv32i_pkg::*;

    instr_pkt_t          entries [IN_DEPTH];
    logic [IN_PTR_W-1:0] wr_ptr;
    logic [IN_PTR_W-1:0] rd_ptr;
    logic [IN_CNT_W-1:0] count;

    function automatic logic [IN_PTR_W-1:0] ptr_next(input logic [IN_PTR_W-1:0] p);
        ptr_next = (p == IN_PTR_W'(IN_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end
        else
        begin
            if (in_valid)
                wr_ptr <= ptr_next(wr_ptr);
            if (issue)
                rd_ptr <= ptr_next(rd_ptr);
            count     <= count + IN_CNT_W'(in_valid) - IN_CNT_W'(issue);
            in_credit <= issue;  // One credit back per pop.
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
            entries[wr_ptr] <= in_pkt;
    end

    assign head_valid = (count != '0);
    assign head_pkt   = entries[rd_ptr];

    // Upstream credits must keep a full buffer from being written.
    assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> count != IN_CNT_W'(IN_DEPTH));

endmodule

//--- logic/regfile.sv
module regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 we,
    input  rv32i_pkg::rv32i_reg  rd,
    input  rv32i_pkg::rv32i_word wdata,
    input  rv32i_pkg::rv32i_reg  rs1,
    input  rv32i_pkg::rv32i_reg  rs2,
    output rv32i_pkg::rv32i_word rs1_data,
    output rv32i_pkg::rv32i_word rs2_data
);
    import rv32i_pkg::*;

    rv32i_word regs [NUM_REGS];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (we && rd != '0)  // x0 ignores writes.
        begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

//--- logic/rv32i_pkg.sv
package rv32i_pkg;

    localparam int IN_DEPTH    = 4;  // Buffer entries and initial upstream credits.
    localparam int OUT_CREDITS = 2;  // Initial credits toward downstream.
    localparam int IN_PTR_W    = $clog2(IN_DEPTH);
    localparam int IN_CNT_W    = $clog2(IN_DEPTH + 1);
    localparam int OUT_CNT_W   = $clog2(OUT_CREDITS + 1);
    localparam int NUM_REGS    = 32;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        add  = 3'b000,  // SUB shares this code.
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101,  // SRL or SRA by funct7 bit 5.
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_t;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops;

    typedef enum logic [2:0] {
        alumux_rs1_out,
        alumux_pc_out,
        alumux_i_imm,
        alumux_u_imm,
        alumux_b_imm,
        alumux_s_imm,
        alumux_j_imm,
        alumux_rs2_out
    } alumux_sel_t;

    typedef enum logic {
        cmpmux_rs2_out,
        cmpmux_i_imm
    } cmpmux_sel_t;

    typedef enum logic [1:0] {
        pcmux_pc_plus4,
        pcmux_alu_out,
        pcmux_alu_mod2,
        pcmux_br_target
    } pcmux_sel_t;

    typedef enum logic [1:0] {
        regfilemux_alu_out,
        regfilemux_br_en,
        regfilemux_u_imm,
        regfilemux_pc_plus4
    } regfilemux_sel_t;

    typedef struct packed {
        logic [6:0] funct7;
        rv32i_reg   rs2;
        rv32i_reg   rs1;
        logic [2:0] funct3;
        rv32i_reg   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        rv32i_reg    rs1;
        logic [2:0]  funct3;
        rv32i_reg    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        rv32i_reg   rs2;
        rv32i_reg   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        rv32i_reg   rs2;
        rv32i_reg   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        rv32i_reg    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        rv32i_reg   rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } rv32i_instr_u;

    typedef struct packed {
        rv32i_opcode     opcode;
        logic [2:0]      funct3;
        logic [6:0]      funct7;
        rv32i_reg        rs1;
        rv32i_reg        rs2;
        rv32i_reg        rd;
        rv32i_word       i_imm;
        rv32i_word       s_imm;
        rv32i_word       b_imm;
        rv32i_word       u_imm;
        rv32i_word       j_imm;
        alumux_sel_t     alumux1_sel;
        alumux_sel_t     alumux2_sel;
        cmpmux_sel_t     cmpmux_sel;
        pcmux_sel_t      pcmux_sel;
        regfilemux_sel_t regfilemux_sel;
        alu_ops          aluop;
        branch_funct3_t  cmpop;
        logic            load_regfile;
        logic            data_read;
        logic            data_write;
        logic            load_pc;
    } rv32i_control_word;

    typedef struct packed {
        rv32i_word    pc;
        rv32i_instr_u instr;
    } instr_pkt_t;

    typedef struct packed {
        rv32i_word pc;
        rv32i_word next_pc;
        rv32i_reg  rd;
        rv32i_word rd_data;
        logic      rd_we;
        rv32i_word mem_addr;
        rv32i_word mem_wdata;
        logic      mem_read;
        logic      mem_write;
        logic      br_taken;
    } commit_t;

endpackage

//--- verification/exec_core_tb.sv
module exec_core_tb;
    import rv32i_pkg::*;

    localparam int NUM_PAT    = 28;
    localparam int PAT_COLS   = 11;
    localparam int RST_CYCLES = 5;
    localparam int MAX_CYCLES = NUM_PAT * 8 + RST_CYCLES + 100;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    instr_pkt_t in_pkt;
    logic       in_credit;
    logic       commit_valid;
    commit_t    commit;
    logic       commit_credit;

    // Columns: pc, instr, rd, rd_data, rd_we, next_pc, mem_addr, mem_wdata,
    // mem_read, mem_write, br_taken.
    rv32i_word   pat_mem [NUM_PAT * PAT_COLS];
    int          cycle        = 0;
    int          up_credits   = IN_DEPTH;
    int          down_credits = OUT_CREDITS;
    int          commit_idx   = 0;
    int          errors       = 0;
    int          checks       = 0;
    int          ret_due [$];  // Cycle at which each downstream credit goes back.
    logic [31:0] lcg_state;

    exec_core uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_pkt        (in_pkt),
        .in_credit     (in_credit),
        .commit_valid  (commit_valid),
        .commit        (commit),
        .commit_credit (commit_credit)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);
    endfunction

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_word(input string name, input rv32i_word exp, input rv32i_word act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input rv32i_reg exp, input rv32i_reg act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("Fail at %0t: %s expected x%0d, got x%0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_commit();
        int base;
        int errs_before;
        base        = commit_idx * PAT_COLS;
        errs_before = errors;
        if (commit_idx >= NUM_PAT)
        begin
            errors++;
            $display("Unexpected extra commit at %0t with pc %h", $time, commit.pc);
        end
        else
        begin
            check_word("pc", pat_mem[base], commit.pc);  // Order check.
            if (pat_mem[base + 4][0] || pat_mem[base + 8][0])
                check_reg("rd", pat_mem[base + 2][4:0], commit.rd);
            if (pat_mem[base + 4][0])
                check_word("rd_data", pat_mem[base + 3], commit.rd_data);
            check_bit("rd_we", pat_mem[base + 4][0], commit.rd_we);
            check_word("next_pc", pat_mem[base + 5], commit.next_pc);
            if (pat_mem[base + 8][0] || pat_mem[base + 9][0])
                check_word("mem_addr", pat_mem[base + 6], commit.mem_addr);
            if (pat_mem[base + 9][0])
                check_word("mem_wdata", pat_mem[base + 7], commit.mem_wdata);
            check_bit("mem_read", pat_mem[base + 8][0], commit.mem_read);
            check_bit("mem_write", pat_mem[base + 9][0], commit.mem_write);
            check_bit("br_taken", pat_mem[base + 10][0], commit.br_taken);
            $display("Instr %0d pc %h: %s", commit_idx, commit.pc,
                     (errors == errs_before) ? "ok" : "mismatch");
        end
        commit_idx++;
    endtask

    // Credit bookkeeping and commit checks, sampled on the clock edge.
    always @(posedge clk)
    begin
        cycle++;
        if (rst_n)
        begin
            up_credits = up_credits + int'(in_credit) - int'(in_valid);
            if (commit_valid)
            begin
                if (down_credits == 0)
                begin
                    errors++;
                    $display("Commit at %0t was issued with no downstream credit", $time);
                end
                down_credits--;
                ret_due.push_back(cycle + lcg_next() % 4);
                check_commit();
            end
            down_credits += int'(commit_credit);  // Counted after the check.
        end
    end

    // Downstream returns at most one credit per cycle, in order.
    initial
    begin
        commit_credit = 1'b0;
        forever
        begin
            step_cycle();
            commit_credit = 1'b0;
            if (ret_due.size() > 0 && ret_due[0] <= cycle)
            begin
                void'(ret_due.pop_front());
                commit_credit = 1'b1;
            end
        end
    end

    initial
    begin
        wait (cycle >= MAX_CYCLES);
        $display("Timeout: %0d of %0d instructions committed after %0d cycles",
                 commit_idx, NUM_PAT, cycle);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        int gap;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_pkt    = '0;
        lcg_state = 32'd88;
        $readmemh("verification/exec_patterns.hex", pat_mem);
        if ($isunknown(pat_mem[NUM_PAT * PAT_COLS - 1]))
        begin
            errors++;
            $display("Pattern file is missing or holds too few entries");
        end
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < NUM_PAT; i++)
        begin
            gap = lcg_next() % 4;
            repeat (gap) step_cycle();
            while (up_credits == 0)
                step_cycle();
            in_valid     = 1'b1;
            in_pkt.pc    = pat_mem[i * PAT_COLS];
            in_pkt.instr = pat_mem[i * PAT_COLS + 1];
            step_cycle();
            in_valid = 1'b0;
        end

        wait (commit_idx == NUM_PAT);
        repeat (6) step_cycle();  // Let the last credit pulses land.
        if (up_credits != IN_DEPTH)
        begin
            errors++;
            $display("Upstream holds %0d credits after draining, not %0d", up_credits, IN_DEPTH);
        end
        if (down_credits != OUT_CREDITS)
        begin
            errors++;
            $display("DUT holds %0d downstream credits after draining, not %0d",
                     down_credits, OUT_CREDITS);
        end
        $display("Done: %0d of %0d instructions committed, %0d checks, %0d errors",
                 commit_idx, NUM_PAT, checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- verification/exec_patterns.hex
// pc instr rd rd_data rd_we next_pc mem_addr mem_wdata mem_read mem_write br_taken
// Unused fields are zero; registers start at zero after reset.
00000100 00500093 01 00000005 1 00000104 00000000 00000000 0 0 0
00000104 ffd00113 02 fffffffd 1 00000108 00000000 00000000 0 0 0
00000108 800001b7 03 80000000 1 0000010c 00000000 00000000 0 0 0
0000010c 00208233 04 00000002 1 00000110 00000000 00000000 0 0 0
00000110 402082b3 05 00000008 1 00000114 00000000 00000000 0 0 0
00000114 0020c333 06 fffffff8 1 00000118 00000000 00000000 0 0 0
00000118 0020e3b3 07 fffffffd 1 0000011c 00000000 00000000 0 0 0
0000011c 0020f433 08 00000005 1 00000120 00000000 00000000 0 0 0
00000120 001114b3 09 ffffffa0 1 00000124 00000000 00000000 0 0 0
00000124 0011d533 0a 04000000 1 00000128 00000000 00000000 0 0 0
00000128 4011d5b3 0b fc000000 1 0000012c 00000000 00000000 0 0 0
0000012c 40115613 0c fffffffe 1 00000130 00000000 00000000 0 0 0
00000130 00708013 00 00000000 0 00000134 00000000 00000000 0 0 0
00000134 001126b3 0d 00000001 1 00000138 00000000 00000000 0 0 0
00000138 00113733 0e 00000000 1 0000013c 00000000 00000000 0 0 0
0000013c 00012793 0f 00000001 1 00000140 00000000 00000000 0 0 0
00000140 00103813 10 00000001 1 00000144 00000000 00000000 0 0 0
00000144 00808863 00 00000000 0 00000154 00000000 00000000 0 0 1
00000148 00809863 00 00000000 0 0000014c 00000000 00000000 0 0 0
0000014c fe114ce3 00 00000000 0 00000144 00000000 00000000 0 0 1
00000150 fe115ce3 00 00000000 0 00000154 00000000 00000000 0 0 0
00000154 00116463 00 00000000 0 00000158 00000000 00000000 0 0 0
00000158 00117463 00 00000000 0 00000160 00000000 00000000 0 0 1
0000015c 020008ef 11 00000160 1 0000017c 00000000 00000000 0 0 0
00000160 01008967 12 00000164 1 00000014 00000000 00000000 0 0 0
00000164 12345997 13 12345164 1 00000168 00000000 00000000 0 0 0
00000168 00c0aa03 14 00000000 0 0000016c 00000011 00000000 1 0 0
0000016c fe312e23 00 00000000 0 00000170 fffffff9 80000000 0 1 0
